// ==== common/super_fec_consts.svh ====
/*
  word width, frame geometry, FIFO depth and
  generator polynomial of the I.3 inner BCH code
*/

`ifndef SUPER_FEC_CONSTS_SVH
`define SUPER_FEC_CONSTS_SVH

// stream word width
`define SF_DAT_W 8

// frame geometry in words
`define SF_DATA_WORDS 242
`define SF_FRAME_WORDS 255

// parity bits, also the LFSR length
`define SF_PAR_W 110

// BCH(2040,1930) generator, MSB is x^110
`define SF_GPOLY 111'h504D1D2EBB0F1D7EFCBF489ED547

// ingress depth, also the credits owned by the source after reset
`define SF_FIFO_DEPTH 256

`endif

// ==== common/super_fec_pkg.sv ====
/*
  stream word, LFSR and word counter types
  state enums for assembler and encoder
  single-bit LFSR step shared by encoder and checker
*/

`include "super_fec_consts.svh"

package super_fec_pkg;

  typedef logic [`SF_DAT_W-1:0] dat_t;
  typedef logic [`SF_PAR_W-1:0] lfsr_t;
  typedef logic [7:0]           wcnt_t;

  typedef enum logic [1:0] {IDLE, PAYLOAD, PARITY} asm_state_t;
  typedef enum logic {PH_DATA, PH_CODE} enc_phase_t;

  // --------------------
  // generator taps in shift order
  // --------------------

  // bit i of the register takes generator coefficient x^(109-i), leading term dropped
  function automatic lfsr_t gpoly_reverse();
    logic [`SF_PAR_W:0] gp;
    lfsr_t              rev;
    gp = `SF_GPOLY;
    for (int i = 0; i < `SF_PAR_W; i++) begin
      rev[i] = gp[`SF_PAR_W-1-i];
    end
    return rev;
  endfunction

  localparam lfsr_t gpoly_rev = gpoly_reverse();

  // one division step, LSB first, register shifts right
  function automatic lfsr_t lfsr_step(input logic din, input lfsr_t st);
    logic fb;
    fb = din ^ st[0];
    return (st >> 1) ^ (fb ? gpoly_rev : lfsr_t'(0));
  endfunction

endpackage

// ==== logic/ingress_fifo.sv ====
/*
  payload ingress FIFO
  circular buffer with occupancy count and one credit returned per pop
*/

`include "super_fec_consts.svh"

module ingress_fifo (
  input  logic                iclk,
  input  logic                ireset,
  input  logic                push,
  input  super_fec_pkg::dat_t wdat,
  input  logic                pop,
  output super_fec_pkg::dat_t rdat,
  output logic [8:0]          count,
  output logic                credit
);

  import super_fec_pkg::*;

  localparam int ptr_w = $clog2(`SF_FIFO_DEPTH);

  dat_t             mem [`SF_FIFO_DEPTH];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;

  // --------------------
  // storage
  // --------------------

  always_ff @(posedge iclk) begin
    if (push) begin
      mem[wr_ptr] <= wdat;
    end
  end

  // head word is always visible to the assembler
  assign rdat = mem[rd_ptr];

  // --------------------
  // pointers, occupancy, credit return
  // --------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      // pointers wrap naturally at the power-of-two depth
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // one credit back per word taken out, one cycle later
      credit <= pop;
    end
  end

endmodule

// ==== logic/frame_assembler.sv ====
/*
  frame-slot sequencer
  waits for a full payload, then emits 242 payload words and 13 zero parity slots
*/

`include "super_fec_consts.svh"

module frame_assembler (
  input  logic                iclk,
  input  logic                ireset,
  input  logic [8:0]          count,
  input  super_fec_pkg::dat_t rdat,
  output logic                pop,
  output logic                val,
  output logic                sop,
  output super_fec_pkg::dat_t dat
);

  import super_fec_pkg::*;

  asm_state_t state;
  wcnt_t      cnt;

  // --------------------
  // sequencer
  // --------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state <= IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        IDLE: begin
          // start only when the whole payload is already buffered
          if (count >= 9'(`SF_DATA_WORDS)) begin
            state <= PAYLOAD;
          end
          cnt <= '0;
        end
        PAYLOAD: begin
          cnt <= cnt + 1'b1;
          if (cnt == wcnt_t'(`SF_DATA_WORDS - 1)) begin
            state <= PARITY;
          end
        end
        PARITY: begin
          cnt <= cnt + 1'b1;
          // last parity slot, go look for the next payload
          if (cnt == wcnt_t'(`SF_FRAME_WORDS - 1)) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // --------------------
  // stream outputs
  // --------------------

  // payload words go straight from the FIFO head
  assign pop = (state == PAYLOAD);
  assign val = (state != IDLE);
  assign sop = (state == PAYLOAD) && (cnt == '0);
  // parity slots carry zero, the encoder fills them in
  assign dat = (state == PAYLOAD) ? rdat : '0;

endmodule

// ==== bch_enc/bch_inner_enc.sv ====
/*
  inner BCH(2040,1930) encoder, 8 bits per word
  LSB-first LFSR division, parity merged into word 242 and shifted out after it
*/

`include "super_fec_consts.svh"

module bch_inner_enc (
  input  logic                iclk,
  input  logic                ireset,
  input  logic                ival,
  input  logic                isop,
  input  super_fec_pkg::dat_t idat,
  output logic                oval,
  output logic                osop,
  output super_fec_pkg::dat_t odat
);

  import super_fec_pkg::*;

  // payload bits in the last data word, 1930 - 241*8
  localparam int last_bits = `SF_DAT_W * `SF_FRAME_WORDS - `SF_PAR_W
                           - `SF_DAT_W * (`SF_DATA_WORDS - 1);
  // parity bits sharing that word
  localparam int par_in_last = `SF_DAT_W - last_bits;

  enc_phase_t phase;
  wcnt_t      cnt;
  wcnt_t      word_no;
  logic       in_data;
  logic       last_dat;
  lfsr_t      state;
  lfsr_t      st_data;

  // --------------------
  // word position and data division
  // --------------------

  always_comb begin
    // number of the current word, 1 on sop
    word_no  = isop ? wcnt_t'(1) : wcnt_t'(cnt + 1'b1);
    in_data  = isop | (phase == PH_DATA);
    last_dat = in_data & (word_no == wcnt_t'(`SF_DATA_WORDS));
    // sop restarts the division from zero
    st_data  = isop ? '0 : state;
    for (int b = 0; b < `SF_DAT_W; b++) begin
      // last data word only feeds its low payload bits
      if (!last_dat || (b < last_bits)) begin
        st_data = lfsr_step(idat[b], st_data);
      end
    end
  end

  // --------------------
  // control
  // --------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oval  <= 1'b0;
      osop  <= 1'b0;
      cnt   <= '0;
      phase <= PH_CODE;
    end else begin
      oval <= ival;
      osop <= ival & isop;
      if (ival) begin
        cnt <= word_no;
        if (isop) begin
          phase <= PH_DATA;
        end else if (last_dat) begin
          phase <= PH_CODE;
        end
      end
    end
  end

  // --------------------
  // data path and parity insertion
  // --------------------

  always_ff @(posedge iclk) begin
    if (ival) begin
      if (last_dat) begin
        // first parity bits ride in the high part of the last data word
        odat  <= {st_data[par_in_last-1:0], idat[last_bits-1:0]};
        state <= st_data >> par_in_last;
      end else if (in_data) begin
        odat  <= idat;
        state <= st_data;
      end else begin
        // parity slots, remainder leaves one byte per word
        odat  <= state[`SF_DAT_W-1:0];
        state <= state >> `SF_DAT_W;
      end
    end
  end

endmodule

// ==== bch_chk/bch_inner_chk.sv ====
/*
  inner BCH(2040,1930) syndrome checker
  divides each received frame by the generator, flags a nonzero remainder
*/

`include "super_fec_consts.svh"

module bch_inner_chk (
  input  logic                iclk,
  input  logic                ireset,
  input  logic                rx_val,
  input  logic                rx_sop,
  input  super_fec_pkg::dat_t rx_dat,
  output logic                chk_val,
  output logic                chk_err
);

  import super_fec_pkg::*;

  wcnt_t cnt;
  wcnt_t word_no;
  logic  busy;
  logic  last;
  lfsr_t rem;
  lfsr_t rem_next;

  // --------------------
  // division of the received codeword
  // --------------------

  always_comb begin
    word_no  = rx_sop ? wcnt_t'(1) : wcnt_t'(cnt + 1'b1);
    last     = (rx_sop | busy) & (word_no == wcnt_t'(`SF_FRAME_WORDS));
    rem_next = rx_sop ? '0 : rem;
    // bit order on the wire already matches the encoder, word 242 included
    for (int b = 0; b < `SF_DAT_W; b++) begin
      rem_next = lfsr_step(rx_dat[b], rem_next);
    end
  end

  always_ff @(posedge iclk) begin
    if (rx_val) begin
      rem <= rem_next;
    end
  end

  // --------------------
  // frame tracking and verdict
  // --------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      cnt     <= '0;
      busy    <= 1'b0;
      chk_val <= 1'b0;
      chk_err <= 1'b0;
    end else begin
      chk_val <= rx_val & last;
      if (rx_val) begin
        cnt <= word_no;
        // words without a preceding sop are ignored
        if (rx_sop) begin
          busy <= 1'b1;
        end else if (last) begin
          busy <= 1'b0;
        end
        // any leftover remainder means a corrupted codeword
        if (last) begin
          chk_err <= |rem_next;
        end
      end
    end
  end

endmodule

// ==== logic/super_i3_inner_top.sv ====
/*
  I.3 inner code top level
  ingress FIFO, frame assembler, BCH encoder and syndrome checker
*/

`include "super_fec_consts.svh"

module super_i3_inner_top (
  input  logic                iclk,
  input  logic                ireset,
  input  logic                in_val,
  input  logic [`SF_DAT_W-1:0] in_dat,
  output logic                in_credit,
  output logic                out_val,
  output logic                out_sop,
  output logic [`SF_DAT_W-1:0] out_dat,
  input  logic                rx_val,
  input  logic                rx_sop,
  input  logic [`SF_DAT_W-1:0] rx_dat,
  output logic                chk_val,
  output logic                chk_err
);

  import super_fec_pkg::*;

  // FIFO to assembler
  logic [8:0] fifo_count;
  dat_t       fifo_rdat;
  logic       asm_pop;

  // assembler to encoder
  logic       asm_val;
  logic       asm_sop;
  dat_t       asm_dat;

  ingress_fifo i_ingress_fifo (
    .iclk   (iclk),
    .ireset (ireset),
    .push   (in_val),
    .wdat   (in_dat),
    .pop    (asm_pop),
    .rdat   (fifo_rdat),
    .count  (fifo_count),
    .credit (in_credit)
  );

  frame_assembler i_frame_assembler (
    .iclk   (iclk),
    .ireset (ireset),
    .count  (fifo_count),
    .rdat   (fifo_rdat),
    .pop    (asm_pop),
    .val    (asm_val),
    .sop    (asm_sop),
    .dat    (asm_dat)
  );

  bch_inner_enc i_bch_inner_enc (
    .iclk   (iclk),
    .ireset (ireset),
    .ival   (asm_val),
    .isop   (asm_sop),
    .idat   (asm_dat),
    .oval   (out_val),
    .osop   (out_sop),
    .odat   (out_dat)
  );

  // receive side is independent of the transmit chain
  bch_inner_chk i_bch_inner_chk (
    .iclk    (iclk),
    .ireset  (ireset),
    .rx_val  (rx_val),
    .rx_sop  (rx_sop),
    .rx_dat  (rx_dat),
    .chk_val (chk_val),
    .chk_err (chk_err)
  );

endmodule

// ==== tests/super_i3_inner_chk.sv ====
/*
  bound assertions for the I.3 inner top level
  ingress overflow, output frame shape, checker verdict timing
*/

`include "super_fec_consts.svh"

module super_i3_inner_chk (
  input logic       iclk,
  input logic       ireset,
  input logic       push,
  input logic [8:0] fifo_count,
  input logic       out_val,
  input logic       out_sop,
  input logic       rx_val,
  input logic       rx_sop,
  input logic       chk_val
);

  // words seen so far in the current output and receive frame
  int out_run;
  int rx_run;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      out_run <= 0;
      rx_run  <= 0;
    end else begin
      out_run <= out_val ? (out_sop ? 1 : out_run + 1) : 0;
      if (rx_val) begin
        rx_run <= rx_sop ? 1 : rx_run + 1;
      end
    end
  end

  // --------------------
  // credit and frame rules
  // --------------------

  // a push needs a credit, so a full FIFO never sees one
  a_no_overflow: assert property (@(posedge iclk) disable iff (ireset)
    push |-> fifo_count < 9'(`SF_FIFO_DEPTH))
    else $error("push while the ingress FIFO holds %0d words", fifo_count);

  // sop opens a frame only after the previous one is complete
  a_sop_first: assert property (@(posedge iclk) disable iff (ireset)
    out_sop |-> out_val && (out_run == 0 || out_run == `SF_FRAME_WORDS))
    else $error("out_sop after %0d words of the previous frame", out_run);

  a_frame_body: assert property (@(posedge iclk) disable iff (ireset)
    out_val && !out_sop |-> out_run >= 1 && out_run < `SF_FRAME_WORDS)
    else $error("out_val word %0d outside a frame", out_run + 1);

  // valid may drop only between frames
  a_frame_end: assert property (@(posedge iclk) disable iff (ireset)
    !out_val |-> out_run == 0 || out_run == `SF_FRAME_WORDS)
    else $error("out_val dropped after %0d words", out_run);

  a_chk_timing: assert property (@(posedge iclk) disable iff (ireset)
    chk_val |-> $past(rx_val) && rx_run == `SF_FRAME_WORDS)
    else $error("chk_val without a completed frame, %0d words", rx_run);

endmodule

// ==== tests/tb_super_i3_inner.sv ====
/*
  directed testbench for the I.3 inner code top level
  credit-gated source, long-division reference encoder,
  loopback into the syndrome checker with and without bit flips
*/

`include "super_fec_consts.svh"

module tb_super_i3_inner;

  localparam int frame_w   = `SF_FRAME_WORDS;
  localparam int data_w    = `SF_DATA_WORDS;
  localparam int code_bits = `SF_FRAME_WORDS * `SF_DAT_W;
  localparam int info_bits = code_bits - `SF_PAR_W;
  localparam int wait_max  = 4000;

  logic       iclk;
  logic       ireset;
  logic       in_val;
  logic [7:0] in_dat;
  logic       in_credit;
  logic       out_val;
  logic       out_sop;
  logic [7:0] out_dat;
  logic       rx_val;
  logic       rx_sop;
  logic [7:0] rx_dat;
  logic       chk_val;
  logic       chk_err;

  int         seed;
  int         err_cnt;
  int         chk_cnt;
  int         timeout_cnt;
  int         sent_cnt;
  int         credit_ret;
  logic [7:0] sent_q[$];
  logic [7:0] cap_q[$];
  logic       sop_q[$];
  logic       chk_q[$];
  int         flips[$];
  logic       cw[code_bits];
  logic [7:0] exp_w[frame_w];

  super_i3_inner_top i_super_i3_inner_top (
    .iclk      (iclk),
    .ireset    (ireset),
    .in_val    (in_val),
    .in_dat    (in_dat),
    .in_credit (in_credit),
    .out_val   (out_val),
    .out_sop   (out_sop),
    .out_dat   (out_dat),
    .rx_val    (rx_val),
    .rx_sop    (rx_sop),
    .rx_dat    (rx_dat),
    .chk_val   (chk_val),
    .chk_err   (chk_err)
  );

  bind super_i3_inner_top super_i3_inner_chk i_chk (
    .iclk       (iclk),
    .ireset     (ireset),
    .push       (in_val),
    .fifo_count (fifo_count),
    .out_val    (out_val),
    .out_sop    (out_sop),
    .rx_val     (rx_val),
    .rx_sop     (rx_sop),
    .chk_val    (chk_val)
  );

  initial iclk = 1'b0;
  always #4 iclk = ~iclk;

  // --------------------
  // monitor takes registered outputs at the rising edge
  // --------------------

  always @(posedge iclk) begin
    if (!ireset) begin
      if (in_credit) begin
        credit_ret = credit_ret + 1;
      end
      if (out_val) begin
        cap_q.push_back(out_dat);
        sop_q.push_back(out_sop);
      end
      if (chk_val) begin
        chk_q.push_back(chk_err);
      end
    end
  end

  // --------------------
  // helpers
  // --------------------

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic note_timeout(input string what);
    timeout_cnt++;
    $display("timeout: gave up waiting for %s", what);
  endtask

  function automatic int rand_pos(input int lo, input int span);
    return lo + ({$random(seed)} % span);
  endfunction

  // source sends one word per cycle while a credit is held
  task automatic send_words(input int n, input logic zero);
    int t;
    for (int i = 0; i < n; i++) begin
      t = 0;
      while (sent_cnt - credit_ret >= `SF_FIFO_DEPTH && t < wait_max) begin
        in_val = 1'b0;
        @(negedge iclk);
        t++;
      end
      if (sent_cnt - credit_ret >= `SF_FIFO_DEPTH) begin
        note_timeout("a returned credit");
        break;
      end
      in_val = 1'b1;
      in_dat = zero ? 8'h00 : 8'($random(seed));
      sent_q.push_back(in_dat);
      sent_cnt++;
      @(negedge iclk);
    end
    in_val = 1'b0;
  endtask

  task automatic wait_frames(input int n);
    int t;
    t = 0;
    while (cap_q.size() < n * frame_w && t < wait_max) begin
      @(negedge iclk);
      t++;
    end
    if (cap_q.size() < n * frame_w) begin
      note_timeout($sformatf("output frame %0d", n));
    end
  endtask

  // reference codeword from m(x) * x^110 mod g(x)
  // first wire bit is the top power
  task automatic encode_ref(input int base);
    logic [`SF_PAR_W:0] g;
    g = `SF_GPOLY;
    for (int k = 0; k < code_bits; k++) begin
      cw[k] = (k < info_bits) ? sent_q[base + k / 8][k % 8] : 1'b0;
    end
    for (int k = 0; k < info_bits; k++) begin
      if (cw[k]) begin
        for (int j = 0; j <= `SF_PAR_W; j++) begin
          cw[k + j] = cw[k + j] ^ g[`SF_PAR_W - j];
        end
      end
    end
    // division cleared the message so it goes back in front of the remainder
    for (int k = 0; k < info_bits; k++) begin
      cw[k] = sent_q[base + k / 8][k % 8];
    end
    // wire bit k sits in word k/8 at bit k%8
    for (int w = 0; w < frame_w; w++) begin
      for (int b = 0; b < 8; b++) begin
        exp_w[w][b] = cw[w * 8 + b];
      end
    end
  endtask

  task automatic check_frame(input int f);
    if (cap_q.size() < (f + 1) * frame_w) begin
      err_cnt++;
      $display("output frame %0d was never captured, no compare done", f);
    end else begin
      encode_ref(f * data_w);
      for (int i = 0; i < frame_w; i++) begin
        check_val($sformatf("out_dat frame %0d word %0d", f, i + 1),
                  32'(cap_q[f * frame_w + i]), 32'(exp_w[i]));
        check_val($sformatf("out_sop frame %0d word %0d", f, i + 1),
                  32'(sop_q[f * frame_w + i]), 32'(i == 0));
      end
    end
  endtask

  // replays a captured frame on rx with the wire bits in flips inverted
  task automatic loop_frame(input int f, input logic exp_err, input string tag);
    logic [7:0] w;
    int         n0;
    int         t;
    if (cap_q.size() < (f + 1) * frame_w) begin
      err_cnt++;
      $display("output frame %0d was never captured, loopback skipped", f);
    end else begin
      n0 = chk_q.size();
      for (int i = 0; i < frame_w; i++) begin
        w = cap_q[f * frame_w + i];
        foreach (flips[j]) begin
          if (flips[j] / 8 == i) begin
            w[flips[j] % 8] = ~w[flips[j] % 8];
          end
        end
        rx_val = 1'b1;
        rx_sop = (i == 0);
        rx_dat = w;
        @(negedge iclk);
      end
      rx_val = 1'b0;
      rx_sop = 1'b0;
      t = 0;
      while (chk_q.size() == n0 && t < 50) begin
        @(negedge iclk);
        t++;
      end
      if (chk_q.size() == n0) begin
        note_timeout($sformatf("chk_val after %s frame %0d", tag, f));
      end else begin
        check_val($sformatf("chk_err %s frame %0d", tag, f), 32'(chk_q[n0]), 32'(exp_err));
      end
    end
  endtask

  // --------------------
  // tests
  // --------------------

  task automatic test_reset_idle();
    check_val("out_val after reset", 32'(out_val), 32'(0));
    check_val("in_credit after reset", 32'(in_credit), 32'(0));
    check_val("chk_val after reset", 32'(chk_val), 32'(0));
    // nothing may leave while one word short of a payload
    send_words(data_w - 1, 1'b0);
    repeat (40) @(negedge iclk);
    check_val("words out before a full payload", 32'(cap_q.size()), 32'(0));
  endtask

  task automatic test_single_frame();
    send_words(1, 1'b0);
    wait_frames(1);
    check_frame(0);
  endtask

  task automatic test_credits();
    int t;
    send_words(3 * data_w, 1'b0);
    wait_frames(4);
    t = 0;
    while (credit_ret < 4 * data_w && t < wait_max) begin
      @(negedge iclk);
      t++;
    end
    check_val("in_credit pulses", 32'(credit_ret), 32'(4 * data_w));
    for (int f = 1; f < 4; f++) begin
      check_frame(f);
    end
  endtask

  task automatic test_clean_loopback();
    flips.delete();
    for (int f = 0; f < 4; f++) begin
      loop_frame(f, 1'b0, "clean");
    end
  endtask

  task automatic test_error_injection();
    int a;
    int b;
    int c;
    for (int trial = 0; trial < 4; trial++) begin
      flips.delete();
      flips.push_back(rand_pos(0, code_bits));
      loop_frame(trial, 1'b1, "single flip");
      // parity region only
      flips.delete();
      flips.push_back(rand_pos(info_bits, `SF_PAR_W));
      loop_frame(trial, 1'b1, "parity flip");
      a = rand_pos(0, code_bits);
      b = rand_pos(info_bits, `SF_PAR_W);
      while (b == a) begin
        b = rand_pos(info_bits, `SF_PAR_W);
      end
      c = rand_pos(0, code_bits);
      while (c == a || c == b) begin
        c = rand_pos(0, code_bits);
      end
      flips.delete();
      flips.push_back(a);
      flips.push_back(b);
      flips.push_back(c);
      loop_frame(trial, 1'b1, "triple flip");
    end
    flips.delete();
  endtask

  task automatic test_zero_payload();
    send_words(data_w, 1'b1);
    wait_frames(5);
    check_frame(4);
    // word 242 and the parity words must all be zero
    if (cap_q.size() >= 5 * frame_w) begin
      for (int i = data_w - 1; i < frame_w; i++) begin
        check_val($sformatf("zero payload word %0d", i + 1),
                  32'(cap_q[4 * frame_w + i]), 32'(0));
      end
    end
    loop_frame(4, 1'b0, "zero payload");
  endtask

  // --------------------
  // sequence
  // --------------------

  initial begin
    seed        = 33;
    err_cnt     = 0;
    chk_cnt     = 0;
    timeout_cnt = 0;
    sent_cnt    = 0;
    credit_ret  = 0;
    ireset      = 1'b1;
    in_val      = 1'b0;
    in_dat      = 8'h00;
    rx_val      = 1'b0;
    rx_sop      = 1'b0;
    rx_dat      = 8'h00;
    repeat (8) @(posedge iclk);
    @(negedge iclk);
    ireset = 1'b0;
    @(negedge iclk);
    test_reset_idle();
    test_single_frame();
    test_credits();
    test_clean_loopback();
    test_error_injection();
    test_zero_payload();
    $display("checks: %0d, errors: %0d, timeouts: %0d", chk_cnt, err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== super_i3_inner_top.f ====
+incdir+common
common/super_fec_pkg.sv
logic/ingress_fifo.sv
logic/frame_assembler.sv
bch_enc/bch_inner_enc.sv
bch_chk/bch_inner_chk.sv
logic/super_i3_inner_top.sv
tests/super_i3_inner_chk.sv
tests/tb_super_i3_inner.sv

// ==== Makefile ====
# Verilator build and run of the I.3 inner code testbench

VERILATOR ?= verilator
TOP       ?= tb_super_i3_inner
FILELIST  ?= super_i3_inner_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Test failed
PASS_MSG  ?= Test completed successfully

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard common/* logic/* bch_enc/* bch_chk/* tests/*)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the verdict, an aborted run has no pass line either
run: build
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation reported a failure, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation ended without a verdict, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
